// File: design/mem_pkg.sv
package mem_pkg;

	// Memory geometry
	localparam int ADDR_W = 12;
	localparam int DATA_W = 16;

	// Arbiter ports
	localparam int CLIENTS = 2;
	localparam int CL_DISP = 0;
	localparam int CL_TEST = 1;

	// Read timing
	localparam int BURST    = 8;
	localparam int READ_LAT = 3;

	// Frame buffer, also used as the test region
	localparam logic [ADDR_W-1:0] FB_BASE = 12'h400;
	localparam int FRAME_WORDS = 64;

	// Display FIFO
	localparam int FIFO_DEPTH = 32;
	localparam int LEVEL_W    = 6;

	localparam logic [ADDR_W-1:0] TEST_BASE = FB_BASE;
	localparam int TEST_WORDS = FRAME_WORDS;

	typedef enum logic [1:0] {
		OP_IDLE,
		OP_WRITE,
		OP_READ
	} mem_op_t;

	typedef enum logic [2:0] {
		T_IDLE,
		T_WRITE,
		T_READ_REQ,
		T_READ_WAIT,
		T_DONE
	} test_state_t;

	typedef enum logic [1:0] {
		F_IDLE,
		F_REQ,
		F_WAIT
	} fetch_state_t;

endpackage

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*; (
	input  logic                       clk10M,
	input  logic                       rst_n,
	input  logic [CLIENTS-1:0]         req,
	input  logic                       busy,
	output logic                       grant_valid,
	output logic [$clog2(CLIENTS)-1:0] grant_id,
	output logic [CLIENTS-1:0]         ack
);

	typedef logic [$clog2(CLIENTS)-1:0] id_t;

	id_t  last;
	id_t  pick_id;
	logic pick_valid;

	// Search starts just after the last served client
	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick_id = last;
		for (int k = 1; k <= CLIENTS; k++) begin
			idx = (int'(last) + k) % CLIENTS;
			if (!pick_valid && req[idx]) begin
				pick_valid = 1'b1;
				pick_id = id_t'(idx);
			end
		end
	end

	always_ff @(posedge clk10M) begin
		if (!rst_n) begin
			grant_valid <= 1'b0;
			grant_id <= '0;
			ack <= '0;
			last <= id_t'(CLIENTS - 1);
		end else begin
			grant_valid <= 1'b0;
			ack <= '0;
			// No grant in the cycle of a previous grant, store not yet busy then
			if (pick_valid && !busy && !grant_valid) begin
				grant_valid <= 1'b1;
				grant_id <= pick_id;
				ack[pick_id] <= 1'b1;
				last <= pick_id;
			end
		end
	end

	// Ack goes to a single client that was requesting
	a_ack_onehot: assert property (@(posedge clk10M) disable iff (!rst_n)
		(ack != '0) |-> ($onehot(ack) && ((ack & $past(req)) == ack)))
		else $error("ack not one-hot or not requested");

endmodule

// File: design/mem_store.sv
`timescale 1ns/1ps

module mem_store import mem_pkg::*; (
	input  logic              clk10M,
	input  logic              rst_n,
	input  logic              grant_valid,
	input  mem_op_t           op,
	input  logic [ADDR_W-1:0] addr,
	input  logic [DATA_W-1:0] wdata,
	output logic              busy,
	output logic [DATA_W-1:0] rdata,
	output logic              rvalid
);

	typedef logic [$clog2(READ_LAT)-1:0] lat_t;
	typedef logic [$clog2(BURST)-1:0] burst_t;

	logic [DATA_W-1:0] mem [2**ADDR_W];

	logic              busy_r;
	lat_t              lat_cnt;
	burst_t            bcnt;
	logic [ADDR_W-1:0] raddr;
	logic              emit;
	logic              rd_start;

	assign rd_start = grant_valid && (op == OP_READ);

	// One word leaves the array per cycle once the latency has run out
	assign emit = busy_r && (lat_cnt == '0);

	// Busy until the last word of the burst is on the bus
	assign busy = busy_r || rvalid;

	always_ff @(posedge clk10M) begin
		if (!rst_n) begin
			busy_r <= 1'b0;
			rvalid <= 1'b0;
			lat_cnt <= '0;
			bcnt <= '0;
		end else begin
			rvalid <= emit;
			if (rd_start) begin
				busy_r <= 1'b1;
				// Registered rdata adds one more cycle
				lat_cnt <= lat_t'(READ_LAT - 2);
				bcnt <= '0;
			end else if (busy_r) begin
				if (lat_cnt != '0) begin
					lat_cnt <= lat_cnt - 1'b1;
				end else begin
					bcnt <= bcnt + 1'b1;
					if (bcnt == burst_t'(BURST - 1)) begin
						busy_r <= 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge clk10M) begin
		if (rd_start) begin
			raddr <= addr;
		end else if (emit) begin
			raddr <= raddr + 1'b1;
		end
	end

	// Array port
	always_ff @(posedge clk10M) begin
		if (grant_valid && (op == OP_WRITE)) begin
			mem[addr] <= wdata;
		end
		if (emit) begin
			rdata <= mem[raddr];
		end
	end

	a_no_grant_busy: assert property (@(posedge clk10M) disable iff (!rst_n)
		grant_valid |-> !busy)
		else $error("grant while store busy");

endmodule

// File: design/memory.sv
`timescale 1ns/1ps

module memory import mem_pkg::*; (
	input  logic               clk10M,
	input  logic               rst_n,
	input  logic [CLIENTS-1:0] req,
	input  logic [CLIENTS-1:0] wr,
	input  logic [ADDR_W-1:0]  addr  [CLIENTS],
	input  logic [DATA_W-1:0]  wdata [CLIENTS],
	output logic [CLIENTS-1:0] ack,
	output logic [DATA_W-1:0]  rdata,
	output logic [CLIENTS-1:0] valid
);

	logic                       grant_valid;
	logic [$clog2(CLIENTS)-1:0] grant_id;
	logic [$clog2(CLIENTS)-1:0] rd_id;
	logic                       busy;
	logic                       rvalid;
	mem_op_t                    op;

	always_comb begin
		if (!grant_valid) begin
			op = OP_IDLE;
		end else if (wr[grant_id]) begin
			op = OP_WRITE;
		end else begin
			op = OP_READ;
		end
	end

	// Owner of the burst in flight
	always_ff @(posedge clk10M) begin
		if (!rst_n) begin
			rd_id <= '0;
		end else if (op == OP_READ) begin
			rd_id <= grant_id;
		end
	end

	always_comb begin
		valid = '0;
		valid[rd_id] = rvalid;
	end

	mem_arbiter arb_i (
		.clk10M      (clk10M),
		.rst_n       (rst_n),
		.req         (req),
		.busy        (busy),
		.grant_valid (grant_valid),
		.grant_id    (grant_id),
		.ack         (ack)
	);

	mem_store store_i (
		.clk10M      (clk10M),
		.rst_n       (rst_n),
		.grant_valid (grant_valid),
		.op          (op),
		.addr        (addr[grant_id]),
		.wdata       (wdata[grant_id]),
		.busy        (busy),
		.rdata       (rdata),
		.rvalid      (rvalid)
	);

endmodule

// File: design/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch import mem_pkg::*; (
	input  logic               clk10M,
	input  logic               rst_n,
	input  logic               disp_en,
	input  logic               pix_en,
	input  logic [DATA_W-1:0]  rdata,
	input  logic               mem_valid,
	input  logic               ack,
	output logic               req,
	output logic [ADDR_W-1:0]  addr,
	output logic [DATA_W-1:0]  pixel,
	output logic               pix_valid,
	output logic               sof,
	output logic               underrun,
	output logic [LEVEL_W-1:0] level,
	output logic               empty,
	output logic               full
);

	typedef logic [$clog2(BURST)-1:0] burst_t;
	typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;

	fetch_state_t state;
	burst_t       wcnt;
	logic         drop;
	logic         room;
	logic [ADDR_W-1:0] next_addr;

	logic [DATA_W-1:0] fifo [FIFO_DEPTH];
	ptr_t wptr, rptr;
	logic [$clog2(FRAME_WORDS)-1:0] frame_cnt;
	logic push, pop;

	assign req = (state == F_REQ) && disp_en;
	assign room = (level <= LEVEL_W'(FIFO_DEPTH - BURST));
	assign next_addr = (addr == ADDR_W'(FB_BASE + FRAME_WORDS - BURST)) ?
		FB_BASE : addr + ADDR_W'(BURST);

	// Words of a burst granted around a disable are thrown away
	assign push = mem_valid && disp_en && !drop;
	assign pop = disp_en && pix_en && !empty;
	assign empty = (level == '0);
	assign full = (level == LEVEL_W'(FIFO_DEPTH));

	always_ff @(posedge clk10M) begin
		if (!rst_n) begin
			state <= F_IDLE;
			addr <= FB_BASE;
			wcnt <= '0;
			drop <= 1'b0;
		end else begin
			if (!disp_en) begin
				addr <= FB_BASE;
			end else if ((state == F_REQ) && ack) begin
				addr <= next_addr;
			end
			case (state)
				F_IDLE: begin
					if (disp_en && room) begin
						state <= F_REQ;
					end
				end
				F_REQ: begin
					if (ack) begin
						state <= F_WAIT;
						wcnt <= '0;
						drop <= !disp_en;
					end
				end
				F_WAIT: begin
					if (!disp_en) begin
						drop <= 1'b1;
					end
					if (mem_valid) begin
						wcnt <= wcnt + 1'b1;
						if (wcnt == burst_t'(BURST - 1)) begin
							state <= F_IDLE;
							drop <= 1'b0;
						end
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	// FIFO control and pop side
	always_ff @(posedge clk10M) begin
		if (!rst_n || !disp_en) begin
			wptr <= '0;
			rptr <= '0;
			level <= '0;
			frame_cnt <= '0;
			pix_valid <= 1'b0;
			sof <= 1'b0;
			underrun <= 1'b0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
				frame_cnt <= (frame_cnt == FRAME_WORDS - 1) ? '0 : frame_cnt + 1'b1;
			end
			level <= level + LEVEL_W'(push) - LEVEL_W'(pop);
			pix_valid <= pop;
			sof <= pop && (frame_cnt == '0);
			if (pix_en && empty) begin
				underrun <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk10M) begin
		if (push) begin
			fifo[wptr] <= rdata;
		end
		if (pop) begin
			pixel <= fifo[rptr];
		end
	end

	// Requests are sized so the burst always fits
	a_no_overflow: assert property (@(posedge clk10M) disable iff (!rst_n)
		mem_valid |-> !full)
		else $error("burst word arrived with FIFO full");

endmodule

// File: design/mem_test.sv
`timescale 1ns/1ps

module mem_test import mem_pkg::*; (
	input  logic              clk10M,
	input  logic              rst_n,
	input  logic              start,
	input  logic              invert,
	input  logic [DATA_W-1:0] rdata,
	input  logic              mem_valid,
	input  logic              ack,
	output logic              req,
	output logic              wr,
	output logic [ADDR_W-1:0] addr,
	output logic [DATA_W-1:0] wdata,
	output logic              done,
	output logic              fail
);

	typedef logic [$clog2(BURST)-1:0] burst_t;

	test_state_t       state;
	logic [ADDR_W-1:0] waddr;
	logic [ADDR_W-1:0] raddr;
	logic [ADDR_W-1:0] exp_addr;
	burst_t            ccnt;
	logic              inv;

	// Tag nibble above the address, optionally inverted
	function automatic logic [DATA_W-1:0] pattern(input logic [ADDR_W-1:0] a,
		input logic neg);
		return {4'hA, a} ^ {DATA_W{neg}};
	endfunction

	assign wr = (state == T_WRITE);
	assign addr = wr ? waddr : raddr;
	assign wdata = pattern(waddr, inv);
	assign exp_addr = raddr + ADDR_W'(ccnt);

	always_ff @(posedge clk10M) begin
		if (!rst_n) begin
			state <= T_IDLE;
			req <= 1'b0;
			done <= 1'b0;
			fail <= 1'b0;
			inv <= 1'b0;
			waddr <= TEST_BASE;
			raddr <= TEST_BASE;
			ccnt <= '0;
		end else begin
			case (state)
				T_IDLE, T_DONE: begin
					if (start) begin
						state <= T_WRITE;
						done <= 1'b0;
						fail <= 1'b0;
						inv <= invert;
						waddr <= TEST_BASE;
						raddr <= TEST_BASE;
					end
				end
				// One word per request, req drops for a cycle after each ack
				T_WRITE: begin
					if (!req) begin
						req <= 1'b1;
					end else if (ack) begin
						req <= 1'b0;
						waddr <= waddr + 1'b1;
						if (waddr == ADDR_W'(TEST_BASE + TEST_WORDS - 1)) begin
							state <= T_READ_REQ;
						end
					end
				end
				T_READ_REQ: begin
					if (!req) begin
						req <= 1'b1;
					end else if (ack) begin
						req <= 1'b0;
						ccnt <= '0;
						state <= T_READ_WAIT;
					end
				end
				T_READ_WAIT: begin
					if (mem_valid) begin
						if (rdata != pattern(exp_addr, inv)) begin
							fail <= 1'b1;
						end
						ccnt <= ccnt + 1'b1;
						if (ccnt == burst_t'(BURST - 1)) begin
							if (raddr == ADDR_W'(TEST_BASE + TEST_WORDS - BURST)) begin
								state <= T_DONE;
								done <= 1'b1;
							end else begin
								raddr <= raddr + ADDR_W'(BURST);
								state <= T_READ_REQ;
							end
						end
					end
				end
				default: state <= T_IDLE;
			endcase
		end
	end

endmodule

// File: design/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys import mem_pkg::*; (
	input  logic               clk10M,
	input  logic               rst_n,
	input  logic               start,
	input  logic               invert,
	output logic               done,
	output logic               fail,
	input  logic               disp_en,
	input  logic               pix_en,
	output logic [DATA_W-1:0]  pixel,
	output logic               pix_valid,
	output logic               sof,
	output logic               underrun,
	output logic [LEVEL_W-1:0] level,
	output logic               empty,
	output logic               full
);

	logic [CLIENTS-1:0] req;
	logic [CLIENTS-1:0] wr;
	logic [CLIENTS-1:0] ack;
	logic [CLIENTS-1:0] valid;
	logic [ADDR_W-1:0]  addr  [CLIENTS];
	logic [DATA_W-1:0]  wdata [CLIENTS];
	logic [DATA_W-1:0]  rdata;

	// Display port only reads
	assign wr[CL_DISP] = 1'b0;
	assign wdata[CL_DISP] = '0;

	memory mem_i (
		.clk10M (clk10M),
		.rst_n  (rst_n),
		.req    (req),
		.wr     (wr),
		.addr   (addr),
		.wdata  (wdata),
		.ack    (ack),
		.rdata  (rdata),
		.valid  (valid)
	);

	pixel_fetch disp_i (
		.clk10M    (clk10M),
		.rst_n     (rst_n),
		.disp_en   (disp_en),
		.pix_en    (pix_en),
		.rdata     (rdata),
		.mem_valid (valid[CL_DISP]),
		.ack       (ack[CL_DISP]),
		.req       (req[CL_DISP]),
		.addr      (addr[CL_DISP]),
		.pixel     (pixel),
		.pix_valid (pix_valid),
		.sof       (sof),
		.underrun  (underrun),
		.level     (level),
		.empty     (empty),
		.full      (full)
	);

	mem_test test_i (
		.clk10M    (clk10M),
		.rst_n     (rst_n),
		.start     (start),
		.invert    (invert),
		.rdata     (rdata),
		.mem_valid (valid[CL_TEST]),
		.ack       (ack[CL_TEST]),
		.req       (req[CL_TEST]),
		.wr        (wr[CL_TEST]),
		.addr      (addr[CL_TEST]),
		.wdata     (wdata[CL_TEST]),
		.done      (done),
		.fail      (fail)
	);

endmodule

// File: verif/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

	// Roughly twice two test runs plus five frames at quarter pixel rate
	localparam int RUN_CYCLES = 4 * TEST_WORDS + 16 * (TEST_WORDS / BURST);
	localparam int FRAME_CYCLES = 4 * FRAME_WORDS;
	localparam int MAX_CYCLES = 2 * (2 * RUN_CYCLES + 5 * FRAME_CYCLES);

	logic               clk10M;
	logic               rst_n;
	logic               start;
	logic               invert;
	logic               done;
	logic               fail;
	logic               disp_en;
	logic               pix_en;
	logic [DATA_W-1:0]  pixel;
	logic               pix_valid;
	logic               sof;
	logic               underrun;
	logic [LEVEL_W-1:0] level;
	logic               empty;
	logic               full;

	integer seed;
	int     cycles = 0;
	int     offset = 0;
	int     pix_seen = 0;
	int     sof_seen = 0;
	bit     mon_on = 1'b1;
	bit     exp_inv = 1'b0;

	mem_subsys mem_subsys_i (
		.clk10M    (clk10M),
		.rst_n     (rst_n),
		.start     (start),
		.invert    (invert),
		.done      (done),
		.fail      (fail),
		.disp_en   (disp_en),
		.pix_en    (pix_en),
		.pixel     (pixel),
		.pix_valid (pix_valid),
		.sof       (sof),
		.underrun  (underrun),
		.level     (level),
		.empty     (empty),
		.full      (full)
	);

	initial clk10M = 1'b0;
	always #50 clk10M = ~clk10M;

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	// Tag nibble over the word address, whole word flipped on invert
	function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] a,
		input logic inv);
		logic [DATA_W-1:0] w;
		w = {4'hA, a};
		if (inv) begin
			w = ~w;
		end
		return w;
	endfunction

	always @(posedge clk10M) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Run stopped by timeout after %0d cycles", cycles);
			stop_run();
		end
	end

	// Pixel monitor, address model restarts whenever the display is off
	always @(negedge clk10M) begin
		if (rst_n) begin
			if (pix_valid) begin
				if (mon_on) begin
					expect_eq("pixel", pixel, expected_word(ADDR_W'(FB_BASE + offset), exp_inv));
					expect_eq("sof", sof, offset == 0);
				end
				if (sof) begin
					sof_seen++;
				end
				pix_seen++;
				offset = (offset + 1) % FRAME_WORDS;
			end else begin
				expect_eq("sof", sof, 1'b0);
			end
			if (!disp_en) begin
				offset = 0;
			end
		end
	end

	task automatic pulse_start(input bit inv);
		@(posedge clk10M);
		start <= 1'b1;
		invert <= inv;
		@(posedge clk10M);
		start <= 1'b0;
	endtask

	task automatic wait_done(input bit strobe_pixels);
		@(negedge clk10M);
		expect_eq("done", done, 1'b0);
		while (done !== 1'b1) begin
			@(posedge clk10M);
			if (strobe_pixels) begin
				pix_en <= (($random(seed) & 3) == 0);
			end
			@(negedge clk10M);
		end
		@(posedge clk10M);
		pix_en <= 1'b0;
	endtask

	// Flush, then prefill one burst before any strobe
	task automatic restart_display();
		@(posedge clk10M);
		disp_en <= 1'b0;
		pix_en <= 1'b0;
		repeat (20) @(posedge clk10M);
		disp_en <= 1'b1;
		@(negedge clk10M);
		while (level < BURST) begin
			@(negedge clk10M);
		end
	endtask

	task automatic run_pixels(input int count, input bit every_cycle);
		int issued;
		int seen_start;
		issued = 0;
		seen_start = pix_seen;
		while (issued < count) begin
			@(posedge clk10M);
			if (every_cycle) begin
				pix_en <= 1'b1;
			end else begin
				pix_en <= (($random(seed) & 3) == 0);
			end
			// Strobe only takes a word when one is waiting
			@(negedge clk10M);
			if (disp_en && pix_en && !empty) begin
				issued++;
			end
		end
		@(posedge clk10M);
		pix_en <= 1'b0;
		@(posedge clk10M);
		@(negedge clk10M);
		expect_eq("pixel count", pix_seen - seen_start, count);
	endtask

	task automatic check_after_reset();
		@(negedge clk10M);
		expect_eq("done", done, 1'b0);
		expect_eq("fail", fail, 1'b0);
		expect_eq("pix_valid", pix_valid, 1'b0);
		expect_eq("sof", sof, 1'b0);
		expect_eq("underrun", underrun, 1'b0);
		expect_eq("empty", empty, 1'b1);
	endtask

	task automatic fill_with_display_off();
		pulse_start(1'b0);
		wait_done(1'b0);
		expect_eq("fail", fail, 1'b0);
	endtask

	task automatic stream_two_frames();
		int sof_before;
		sof_before = sof_seen;
		exp_inv = 1'b0;
		restart_display();
		run_pixels(2 * FRAME_WORDS, 1'b0);
		@(negedge clk10M);
		expect_eq("sof count", sof_seen - sof_before, 2);
		expect_eq("underrun", underrun, 1'b0);
	endtask

	// Display keeps fetching while the test rewrites the same region
	task automatic rerun_under_contention();
		mon_on = 1'b0;
		pulse_start(1'b1);
		wait_done(1'b1);
		expect_eq("fail", fail, 1'b0);
		exp_inv = 1'b1;
		restart_display();
		mon_on = 1'b1;
		run_pixels(FRAME_WORDS, 1'b0);
		@(negedge clk10M);
		expect_eq("underrun", underrun, 1'b0);
	endtask

	task automatic hold_back_pressure();
		int seen_before;
		restart_display();
		seen_before = pix_seen;
		repeat (60) @(posedge clk10M);
		@(negedge clk10M);
		expect_eq("full", full, 1'b1);
		expect_eq("level", level, FIFO_DEPTH);
		expect_eq("pix_valid", pix_valid, 1'b0);
		expect_eq("pixels during hold", pix_seen - seen_before, 0);
		run_pixels(40, 1'b0);
		@(negedge clk10M);
		expect_eq("underrun", underrun, 1'b0);
	endtask

	task automatic overrun_bandwidth();
		restart_display();
		run_pixels(48, 1'b1);
		@(negedge clk10M);
		assert (underrun === 1'b1) else begin
			$display("Underrun never rose with pix_en held high every cycle");
			stop_run();
		end
	endtask

	initial begin
		seed = 57;
		rst_n = 1'b0;
		start = 1'b0;
		invert = 1'b0;
		disp_en = 1'b0;
		pix_en = 1'b0;
		repeat (2) @(posedge clk10M);
		rst_n <= 1'b1;

		check_after_reset();
		fill_with_display_off();
		stream_two_frames();
		rerun_under_contention();
		hold_back_pressure();
		overrun_bandwidth();

		$display("TEST OK");
		$finish;
	end

endmodule

// File: flist.f
design/mem_pkg.sv
design/mem_arbiter.sv
design/mem_store.sv
design/memory.sv
design/pixel_fetch.sv
design/mem_test.sv
design/mem_subsys.sv
verif/tb_mem_subsys.sv
